// File: rtl/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// Processor data word width
`define CACHE_WORD_W 16

// Byte address width
`define CACHE_ADDR_W 16

// Line geometry, the same for both caches
`define CACHE_LINE_WORDS 8
`define CACHE_LINES 16

`endif

// File: rtl/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

    //////////////////////////////
    // Address layout
    //////////////////////////////

    // One byte address, seen either flat or split for a direct-mapped lookup
    typedef union packed {
        logic [`CACHE_ADDR_W-1:0] raw;
        struct packed {
            logic [7:0] tag;
            logic [3:0] index;
            logic [2:0] word;
            logic       byte_sel;
        } fields;
    } addr_u;

    //////////////////////////////
    // Refill controller
    //////////////////////////////

    typedef enum logic [1:0] {
        FILL_IDLE = 2'b00,
        FILL_I    = 2'b01,
        FILL_D    = 2'b10
    } fill_state_e;

endpackage

// File: rtl/fill_if.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

interface fill_if;

    // Cache to controller
    logic                      miss;
    cache_pkg::addr_u          miss_addr;

    // Controller to cache
    logic [`CACHE_WORD_W-1:0]  fill_data;
    logic [2:0]                fill_word;
    logic                      fill_we;
    logic                      fill_tag_we;

    modport cache (
        output miss, miss_addr,
        input  fill_data, fill_word, fill_we, fill_tag_we
    );

    modport ctrl (
        input  miss, miss_addr,
        output fill_data, fill_word, fill_we, fill_tag_we
    );

endinterface

// File: rtl/fill_beat_counter.sv
`timescale 1ns/1ps

module fill_beat_counter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clr,
    input  logic       req_inc,
    input  logic       rsp_inc,
    output logic [2:0] req_idx,
    output logic [2:0] rsp_idx,
    output logic       req_done,
    output logic       rsp_last
);

    // Top bit of the request count marks all eight issued
    logic [3:0] req_cnt;
    logic [2:0] rsp_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_cnt <= '0;
        end else if (clr) begin
            req_cnt <= '0;
        end else if (req_inc) begin
            req_cnt <= req_cnt + 4'd1;
        end
    end

    // Responses wrap at eight, the FSM leaves on the last one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_cnt <= '0;
        end else if (clr) begin
            rsp_cnt <= '0;
        end else if (rsp_inc) begin
            rsp_cnt <= rsp_cnt + 3'd1;
        end
    end

    assign req_idx  = req_cnt[2:0];
    assign req_done = req_cnt[3];
    assign rsp_idx  = rsp_cnt;
    assign rsp_last = (rsp_cnt == 3'd7);

endmodule

// File: rtl/fill_fsm.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module fill_fsm (
    input  logic                     clk,
    input  logic                     rst_n,
    fill_if.ctrl                     icache,
    fill_if.ctrl                     dcache,
    input  logic                     mem_ready,
    input  logic                     mem_valid,
    input  logic [`CACHE_WORD_W-1:0] mem_rdata,
    input  logic                     req_done,
    input  logic                     rsp_last,
    input  logic [2:0]               req_idx,
    input  logic [2:0]               rsp_idx,
    output logic                     mem_en,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    output logic                     beat_clr,
    output logic                     req_inc,
    output logic                     rsp_inc,
    output logic                     fill_busy
);

    cache_pkg::fill_state_e state;
    cache_pkg::fill_state_e state_nxt;
    cache_pkg::addr_u       base;
    cache_pkg::addr_u       req_addr;
    logic                   last_beat;
    logic                   fill_i;
    logic                   fill_d;

    //////////////////////////////
    // State register
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cache_pkg::FILL_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign fill_i    = (state == cache_pkg::FILL_I);
    assign fill_d    = (state == cache_pkg::FILL_D);
    assign fill_busy = (state != cache_pkg::FILL_IDLE);
    assign last_beat = mem_valid && rsp_last;

    // Instruction misses win, a pending data miss follows directly
    always_comb begin
        state_nxt = state;
        case (state)
            cache_pkg::FILL_IDLE: begin
                if (icache.miss) begin
                    state_nxt = cache_pkg::FILL_I;
                end else if (dcache.miss) begin
                    state_nxt = cache_pkg::FILL_D;
                end
            end
            cache_pkg::FILL_I: begin
                if (last_beat) begin
                    state_nxt = dcache.miss ? cache_pkg::FILL_D : cache_pkg::FILL_IDLE;
                end
            end
            default: begin
                if (last_beat) begin
                    state_nxt = cache_pkg::FILL_IDLE;
                end
            end
        endcase
    end

    assign beat_clr = (state_nxt != state);

    // Block base taken from whichever miss starts the next fill
    always_ff @(posedge clk) begin
        if (beat_clr && state_nxt != cache_pkg::FILL_IDLE) begin
            base <= (state_nxt == cache_pkg::FILL_I) ? icache.miss_addr : dcache.miss_addr;
        end
    end

    //////////////////////////////
    // Memory request side
    //////////////////////////////

    always_comb begin
        req_addr                 = base;
        req_addr.fields.word     = req_idx;
        req_addr.fields.byte_sel = 1'b0;
    end

    assign mem_addr = req_addr.raw;
    assign mem_en   = fill_busy && !req_done;
    assign req_inc  = mem_en && mem_ready;
    assign rsp_inc  = fill_busy && mem_valid;

    //////////////////////////////
    // Array write steering
    //////////////////////////////

    assign icache.fill_data   = fill_i ? mem_rdata : '0;
    assign icache.fill_word   = fill_i ? rsp_idx : 3'd0;
    assign icache.fill_we     = fill_i && mem_valid;
    assign icache.fill_tag_we = fill_i && last_beat;

    assign dcache.fill_data   = fill_d ? mem_rdata : '0;
    assign dcache.fill_word   = fill_d ? rsp_idx : 3'd0;
    assign dcache.fill_we     = fill_d && mem_valid;
    assign dcache.fill_tag_we = fill_d && last_beat;

endmodule

// File: rtl/cache_array.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_array (
    input  logic                     clk,
    input  logic                     rst_n,
    fill_if.cache                    fill,
    input  logic                     rd,
    input  logic                     wr,
    input  logic [`CACHE_ADDR_W-1:0] addr,
    input  logic [`CACHE_WORD_W-1:0] wdata,
    output logic [`CACHE_WORD_W-1:0] rdata,
    output logic                     ready
);

    cache_pkg::addr_u         a;
    logic [7:0]               tag_mem [`CACHE_LINES];
    logic [`CACHE_LINES-1:0]  valid;
    logic [`CACHE_WORD_W-1:0] data_mem [`CACHE_LINES*`CACHE_LINE_WORDS];
    logic                     req;
    logic                     hit;
    logic [6:0]               rd_slot;
    logic [6:0]               fill_slot;

    assign a.raw = addr;
    assign req   = rd || wr;

    //////////////////////////////
    // Lookup
    //////////////////////////////

    assign hit     = valid[a.fields.index] && (tag_mem[a.fields.index] == a.fields.tag);
    assign rd_slot = {a.fields.index, a.fields.word};

    // Same-cycle answer on a hit
    assign ready = req && hit;
    assign rdata = data_mem[rd_slot];

    assign fill.miss      = req && !hit;
    assign fill.miss_addr = a;

    //////////////////////////////
    // Storage updates
    //////////////////////////////

    // Line stays put while the processor holds its request
    assign fill_slot = {a.fields.index, fill.fill_word};

    always_ff @(posedge clk) begin
        if (fill.fill_we) begin
            data_mem[fill_slot] <= fill.fill_data;
        end else if (wr && hit) begin
            data_mem[rd_slot] <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (fill.fill_tag_we) begin
            tag_mem[a.fields.index] <= a.fields.tag;
        end
    end

    // Valid bit set with the tag, on the last refill word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;
        end else if (fill.fill_tag_we) begin
            valid[a.fields.index] <= 1'b1;
        end
    end

endmodule

// File: rtl/cache_top.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_top (
    input  logic                     clk,
    input  logic                     rst_n,

    // Fetch port
    input  logic                     if_req,
    input  logic [`CACHE_ADDR_W-1:0] if_addr,
    output logic [`CACHE_WORD_W-1:0] if_rdata,
    output logic                     if_ready,

    // Data port
    input  logic                     dm_rd,
    input  logic                     dm_wr,
    input  logic [`CACHE_ADDR_W-1:0] dm_addr,
    input  logic [`CACHE_WORD_W-1:0] dm_wdata,
    output logic [`CACHE_WORD_W-1:0] dm_rdata,
    output logic                     dm_ready,

    // External memory
    output logic                     mem_en,
    output logic [`CACHE_ADDR_W-1:0] mem_addr,
    input  logic                     mem_ready,
    input  logic                     mem_valid,
    input  logic [`CACHE_WORD_W-1:0] mem_rdata,

    output logic                     fill_busy
);

    logic       beat_clr;
    logic       req_inc;
    logic       rsp_inc;
    logic       req_done;
    logic       rsp_last;
    logic [2:0] req_idx;
    logic [2:0] rsp_idx;

    fill_if icache_fill ();
    fill_if dcache_fill ();

    //////////////////////////////
    // Caches
    //////////////////////////////

    // Instruction side never stores
    cache_array icache (
        .clk   (clk),
        .rst_n (rst_n),
        .fill  (icache_fill.cache),
        .rd    (if_req),
        .wr    (1'b0),
        .addr  (if_addr),
        .wdata ('0),
        .rdata (if_rdata),
        .ready (if_ready)
    );

    cache_array dcache (
        .clk   (clk),
        .rst_n (rst_n),
        .fill  (dcache_fill.cache),
        .rd    (dm_rd),
        .wr    (dm_wr),
        .addr  (dm_addr),
        .wdata (dm_wdata),
        .rdata (dm_rdata),
        .ready (dm_ready)
    );

    //////////////////////////////
    // Refill control
    //////////////////////////////

    fill_fsm fill_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .icache    (icache_fill.ctrl),
        .dcache    (dcache_fill.ctrl),
        .mem_ready (mem_ready),
        .mem_valid (mem_valid),
        .mem_rdata (mem_rdata),
        .req_done  (req_done),
        .rsp_last  (rsp_last),
        .req_idx   (req_idx),
        .rsp_idx   (rsp_idx),
        .mem_en    (mem_en),
        .mem_addr  (mem_addr),
        .beat_clr  (beat_clr),
        .req_inc   (req_inc),
        .rsp_inc   (rsp_inc),
        .fill_busy (fill_busy)
    );

    fill_beat_counter beat_cnt (
        .clk      (clk),
        .rst_n    (rst_n),
        .clr      (beat_clr),
        .req_inc  (req_inc),
        .rsp_inc  (rsp_inc),
        .req_idx  (req_idx),
        .rsp_idx  (rsp_idx),
        .req_done (req_done),
        .rsp_last (rsp_last)
    );

endmodule

// File: testbench/tb_cache_top.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module tb_cache_top;

    localparam int CLK_PERIOD   = 8;
    localparam int NUM_TESTS    = 6;
    localparam int ACCESS_LIMIT = 400;
    // Four fills per test at the access limit each, doubled as margin
    localparam int WATCHDOG_NS  = NUM_TESTS * 4 * ACCESS_LIMIT * CLK_PERIOD * 2;
    localparam int HIT          = 1;
    localparam int MISS         = 2;

    logic                     clk;
    logic                     rst_n;
    logic                     if_req;
    logic [`CACHE_ADDR_W-1:0] if_addr;
    logic [`CACHE_WORD_W-1:0] if_rdata;
    logic                     if_ready;
    logic                     dm_rd;
    logic                     dm_wr;
    logic [`CACHE_ADDR_W-1:0] dm_addr;
    logic [`CACHE_WORD_W-1:0] dm_wdata;
    logic [`CACHE_WORD_W-1:0] dm_rdata;
    logic                     dm_ready;
    logic                     mem_en;
    logic [`CACHE_ADDR_W-1:0] mem_addr;
    logic                     mem_ready;
    logic                     mem_valid;
    logic [`CACHE_WORD_W-1:0] mem_rdata;
    logic                     fill_busy;

    logic [15:0] pend_addr[$];
    int          pend_due[$];
    logic [15:0] req_log[$];
    logic [15:0] shadow[logic [15:0]];
    int          cyc;
    logic        slow_mem;
    int          test_err;
    int          tests_run;
    int          tests_failed;

    cache_top cache_top_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .if_req    (if_req),
        .if_addr   (if_addr),
        .if_rdata  (if_rdata),
        .if_ready  (if_ready),
        .dm_rd     (dm_rd),
        .dm_wr     (dm_wr),
        .dm_addr   (dm_addr),
        .dm_wdata  (dm_wdata),
        .dm_rdata  (dm_rdata),
        .dm_ready  (dm_ready),
        .mem_en    (mem_en),
        .mem_addr  (mem_addr),
        .mem_ready (mem_ready),
        .mem_valid (mem_valid),
        .mem_rdata (mem_rdata),
        .fill_busy (fill_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Memory model
    //////////////////////////////

    // In-order responses 1 to 4 cycles after acceptance
    initial begin
        int   lat;
        logic slow;
        void'($urandom(32'h1bd35c3f));
        forever begin
            @(posedge clk);
            cyc  = cyc + 1;
            slow = slow_mem;
            if (rst_n && mem_en && mem_ready) begin
                // Requests only go out while a refill is running
                check_val("fill_busy", 16'(fill_busy), 16'h0001);
                lat = 1 + int'($urandom % 32'd4);
                pend_addr.push_back(mem_addr);
                pend_due.push_back(cyc + lat);
                req_log.push_back(mem_addr);
            end
            #1;
            if (pend_addr.size() > 0 && pend_due[0] <= cyc) begin
                mem_valid = 1'b1;
                mem_rdata = pend_addr.pop_front() ^ 16'hA5C3;
                void'(pend_due.pop_front());
            end else begin
                mem_valid = 1'b0;
            end
            mem_ready = slow ? (($urandom % 32'd8) == 32'd0) : (($urandom % 32'd4) != 32'd0);
        end
    end

    function automatic logic [15:0] mem_word(input logic [15:0] addr);
        return (addr & 16'hFFFE) ^ 16'hA5C3;
    endfunction

    // Stores survive only until the line is refilled
    function automatic logic [15:0] expected_word(input logic [15:0] addr);
        logic [15:0] a;
        a = addr & 16'hFFFE;
        return shadow.exists(a) ? shadow[a] : mem_word(a);
    endfunction

    //////////////////////////////
    // Processor side
    //////////////////////////////

    task automatic check_val(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_wait(input logic [15:0] addr, input int mode, input int wait_cyc);
        assert ((mode == HIT) == (wait_cyc == 0)) else begin
            $display("Access to %h %s although a %s was expected", addr,
                     wait_cyc == 0 ? "hit" : "missed", mode == HIT ? "hit" : "miss");
            test_err++;
        end
    endtask

    task automatic fetch_word(input logic [15:0] addr, output logic [15:0] data,
                              output int wait_cyc);
        int n;
        n = 0;
        if_req  = 1'b1;
        if_addr = addr;
        @(negedge clk);
        while (!if_ready && n < ACCESS_LIMIT) begin
            n++;
            @(negedge clk);
        end
        assert (if_ready) else begin
            $display("Fetch of %h never became ready", addr);
            test_err++;
        end
        data     = if_rdata;
        wait_cyc = n;
        @(posedge clk);
        #1;
        if_req = 1'b0;
    endtask

    task automatic data_access(input logic is_wr, input logic [15:0] addr,
                               input logic [15:0] wdata, output logic [15:0] data,
                               output int wait_cyc);
        int n;
        n = 0;
        dm_rd    = !is_wr;
        dm_wr    = is_wr;
        dm_addr  = addr;
        dm_wdata = wdata;
        @(negedge clk);
        while (!dm_ready && n < ACCESS_LIMIT) begin
            n++;
            @(negedge clk);
        end
        assert (dm_ready) else begin
            $display("Data access to %h never became ready", addr);
            test_err++;
        end
        data     = dm_rdata;
        wait_cyc = n;
        // A miss means the line was just refilled from memory
        if (n > 0) begin
            for (int i = 0; i < 8; i++) begin
                shadow.delete((addr & 16'hFFF0) + 16'(2 * i));
            end
        end
        if (is_wr) begin
            shadow[addr & 16'hFFFE] = wdata;
        end
        @(posedge clk);
        #1;
        dm_rd = 1'b0;
        dm_wr = 1'b0;
    endtask

    task automatic check_fetch(input logic [15:0] addr, input int mode);
        logic [15:0] data;
        int          w;
        fetch_word(addr, data, w);
        check_wait(addr, mode, w);
        check_val("if_rdata", data, mem_word(addr));
    endtask

    task automatic check_read(input logic [15:0] addr, input int mode);
        logic [15:0] data;
        int          w;
        data_access(1'b0, addr, 16'h0000, data, w);
        check_wait(addr, mode, w);
        check_val("dm_rdata", data, expected_word(addr));
    endtask

    task automatic write_word(input logic [15:0] addr, input logic [15:0] value, input int mode);
        logic [15:0] data;
        int          w;
        data_access(1'b1, addr, value, data, w);
        check_wait(addr, mode, w);
    endtask

    task automatic read_line(input logic fetch, input logic [15:0] base);
        for (int i = 0; i < 8; i++) begin
            if (fetch) begin
                check_fetch(base + 16'(2 * i), HIT);
            end else begin
                check_read(base + 16'(2 * i), HIT);
            end
        end
    endtask

    // Eight requests of one fill in order from the block base
    task automatic check_requests(input int first, input logic [15:0] base);
        assert (req_log.size() >= first + 8) else begin
            $display("Only %0d memory requests seen for block %h", req_log.size() - first, base);
            test_err++;
        end
        for (int i = 0; i < 8 && first + i < req_log.size(); i++) begin
            check_val("mem_addr", req_log[first + i], base + 16'(2 * i));
        end
    endtask

    task automatic check_request_total(input int fills);
        check_val("request count", 16'(req_log.size()), 16'(8 * fills));
        check_val("pending responses", 16'(pend_addr.size()), 16'h0000);
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_err == 0) begin
            $display("[PASS] %s", name);
        end else begin
            tests_failed++;
            $display("[FAIL] %s (%0d errors)", name, test_err);
        end
        test_err = 0;
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic test_reset();
        check_val("mem_en", 16'(mem_en), 16'h0000);
        check_val("fill_busy", 16'(fill_busy), 16'h0000);
        check_fetch(16'h0100, MISS);
        end_test("reset and first fetch");
    endtask

    task automatic test_fetch_rehit();
        req_log.delete();
        check_fetch(16'h2346, MISS);
        check_requests(0, 16'h2340);
        check_request_total(1);
        read_line(1'b1, 16'h2340);
        end_test("instruction miss and re-hit");
    endtask

    task automatic test_write_allocate();
        write_word(16'h4A26, 16'h1234, MISS);
        read_line(1'b0, 16'h4A20);
        end_test("data write allocate");
    endtask

    task automatic test_dual_miss();
        logic [15:0] idata;
        logic [15:0] ddata;
        int          iwait;
        int          dwait;
        req_log.delete();
        fork
            fetch_word(16'h6184, idata, iwait);
            data_access(1'b0, 16'h759A, 16'h0000, ddata, dwait);
        join
        check_val("if_rdata", idata, mem_word(16'h6184));
        check_val("dm_rdata", ddata, expected_word(16'h759A));
        assert (iwait > 0 && iwait <= dwait) else begin
            $display("Fetch waited %0d cycles and data waited %0d cycles", iwait, dwait);
            test_err++;
        end
        check_requests(0, 16'h6180);
        check_requests(8, 16'h7590);
        check_request_total(2);
        end_test("simultaneous fetch and data miss");
    endtask

    task automatic test_eviction();
        write_word(16'h1234, 16'hBEEF, MISS);
        check_read(16'h1234, HIT);
        check_read(16'h5634, MISS);
        // Refill from memory drops the earlier store
        check_read(16'h1234, MISS);
        check_read(16'h5634, MISS);
        end_test("conflict eviction");
    endtask

    task automatic test_backpressure();
        slow_mem = 1'b1;
        req_log.delete();
        check_fetch(16'h8A0C, MISS);
        check_read(16'h9C42, MISS);
        check_requests(0, 16'h8A00);
        check_requests(8, 16'h9C40);
        check_request_total(2);
        slow_mem = 1'b0;
        read_line(1'b1, 16'h8A00);
        read_line(1'b0, 16'h9C40);
        end_test("memory back-pressure");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        if_req       = 1'b0;
        if_addr      = '0;
        dm_rd        = 1'b0;
        dm_wr        = 1'b0;
        dm_addr      = '0;
        dm_wdata     = '0;
        mem_ready    = 1'b0;
        mem_valid    = 1'b0;
        mem_rdata    = '0;
        slow_mem     = 1'b0;
        cyc          = 0;
        test_err     = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        test_reset();
        test_fetch_rehit();
        test_write_allocate();
        test_dual_miss();
        test_eviction();
        test_backpressure();
        $display("Tests run: %0d, failed: %0d", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: cache_top.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/fill_if.sv
rtl/fill_beat_counter.sv
rtl/fill_fsm.sv
rtl/cache_array.sv
rtl/cache_top.sv
testbench/tb_cache_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_top
LINT_TOP  ?= cache_top
FILELIST  ?= cache_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
